//--- front_end_pkg.sv
`default_nettype none

package front_end_pkg;

	localparam int num_warps = 4;
	localparam int nw_bits = 2; // Enough to name every warp.
	localparam int xlen = 32;
	localparam int reg_bits = 5;
	localparam int op_bits = 4;

	localparam logic [xlen-1:0] start_pc = 32'h0000_1000;
	localparam logic [xlen-1:0] warp_pc_stride = 32'h100; // Warp w starts w strides up.

	// Payload widths of the fetch, icache and decode stage registers.
	localparam int fi_width = nw_bits + xlen;
	localparam int id_width = nw_bits + 2 * xlen;
	localparam int be_width = nw_bits + xlen + op_bits + 3 * reg_bits + xlen;

	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_system = 7'b1110011;

	localparam logic [xlen-1:0] instr_ecall = 32'h0000_0073;
	localparam logic [xlen-1:0] instr_ebreak = 32'h0010_0073;

	typedef enum logic [op_bits-1:0] {
		op_alu = 4'd0,
		op_alu_imm = 4'd1,
		op_load = 4'd2,
		op_store = 4'd3,
		op_branch = 4'd4,
		op_jal = 4'd5,
		op_jalr = 4'd6,
		op_lui = 4'd7,
		op_auipc = 4'd8,
		op_system_halt = 4'd9,
		op_illegal = 4'd10 // Also what a failed fetch decodes to.
	} op_class_t;

	typedef enum logic [1:0] {
		apb_idle = 2'd0,
		apb_setup = 2'd1,
		apb_access = 2'd2
	} apb_state_t;

endpackage

`default_nettype wire

//--- warp_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module warp_fetch (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic release_valid,
	input  logic [front_end_pkg::nw_bits-1:0] release_wid,
	input  logic redirect_valid,
	input  logic [front_end_pkg::nw_bits-1:0] redirect_wid,
	input  logic [front_end_pkg::xlen-1:0] redirect_pc,
	input  logic halt_valid,
	output logic fetch_valid,
	output logic [front_end_pkg::nw_bits-1:0] fetch_wid,
	output logic [front_end_pkg::xlen-1:0] fetch_pc,
	output logic fetch_halted
);

	logic [front_end_pkg::xlen-1:0] pc_q [front_end_pkg::num_warps];
	logic [front_end_pkg::num_warps-1:0] in_flight_q;
	logic [front_end_pkg::nw_bits-1:0] last_wid_q;
	logic halted_q;
	logic found;
	logic [front_end_pkg::nw_bits-1:0] pick_wid;

	assign fetch_halted = halted_q || halt_valid; // Stops issue in the halt cycle itself.

	// Round robin: first idle warp after the one issued last.
	always_comb begin
		logic [front_end_pkg::nw_bits-1:0] cand;
		found = 1'b0;
		pick_wid = last_wid_q;
		for (int i = 1; i <= front_end_pkg::num_warps; i++) begin
			cand = last_wid_q + i[front_end_pkg::nw_bits-1:0];
			if (!found && !in_flight_q[cand]) begin
				found = 1'b1;
				pick_wid = cand;
			end
		end
	end

	assign fetch_valid = found && !stall && !fetch_halted;
	assign fetch_wid = pick_wid;
	assign fetch_pc = pc_q[pick_wid];

	always_ff @(posedge clk) begin
		if (reset) begin
			in_flight_q <= '0;
			last_wid_q <= '1; // So that warp 0 goes first.
			halted_q <= 1'b0;
			for (int w = 0; w < front_end_pkg::num_warps; w++) begin
				pc_q[w] <= front_end_pkg::start_pc + w * front_end_pkg::warp_pc_stride;
			end
		end else begin
			halted_q <= fetch_halted;
			if (release_valid) begin
				in_flight_q[release_wid] <= 1'b0;
			end
			if (redirect_valid) begin
				in_flight_q[redirect_wid] <= 1'b0;
				pc_q[redirect_wid] <= redirect_pc;
			end
			// Issue comes last so that a release held over a freeze cannot free the new fetch.
			if (fetch_valid) begin
				in_flight_q[fetch_wid] <= 1'b1;
				pc_q[fetch_wid] <= fetch_pc + 32'd4;
				last_wid_q <= fetch_wid;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		fetch_valid |-> !in_flight_q[fetch_wid])
		else $error("warp %0d issued while it still has an instruction in flight", fetch_wid);

endmodule

`default_nettype wire

//--- stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
	parameter int width = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic freeze,
	input  logic in_valid,
	input  logic [width-1:0] in_data,
	output logic out_valid,
	output logic [width-1:0] out_data
);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (!freeze) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			out_data <= in_data;
		end
	end

	// A frozen stage keeps presenting the same instruction downstream.
	assert property (@(posedge clk) disable iff (reset)
		freeze && out_valid |=> out_valid && $stable(out_data))
		else $error("stage register contents changed under freeze");

endmodule

`default_nettype wire

//--- icache_stage.sv
`timescale 1ns/100ps
`default_nettype none

module icache_stage (
	input  logic clk,
	input  logic reset,
	input  logic freeze,
	input  logic fi_valid,
	input  logic [front_end_pkg::nw_bits-1:0] fi_wid,
	input  logic [front_end_pkg::xlen-1:0] fi_pc,
	input  logic [front_end_pkg::xlen-1:0] prdata,
	input  logic pready,
	input  logic pslverr,
	output logic icache_busy,
	output logic id_valid,
	output logic [front_end_pkg::nw_bits-1:0] id_wid,
	output logic [front_end_pkg::xlen-1:0] id_pc,
	output logic [front_end_pkg::xlen-1:0] id_instr,
	output logic psel,
	output logic penable,
	output logic [front_end_pkg::xlen-1:0] paddr
);

	front_end_pkg::apb_state_t state_q;
	front_end_pkg::apb_state_t state_d;
	logic [front_end_pkg::nw_bits-1:0] req_wid_q;
	logic [front_end_pkg::xlen-1:0] req_pc_q;
	logic [front_end_pkg::xlen-1:0] instr_q;
	logic rsp_valid_q;
	logic start;
	logic done;

	// A new request only starts once any pending result has left.
	assign start = (state_q == front_end_pkg::apb_idle) && fi_valid && !freeze;
	assign done = (state_q == front_end_pkg::apb_access) && pready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			front_end_pkg::apb_idle: begin
				if (start) begin
					state_d = front_end_pkg::apb_setup;
				end
			end
			front_end_pkg::apb_setup: begin
				state_d = front_end_pkg::apb_access;
			end
			front_end_pkg::apb_access: begin
				if (pready) begin
					state_d = front_end_pkg::apb_idle;
				end
			end
			default: begin
				state_d = front_end_pkg::apb_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= front_end_pkg::apb_idle;
			rsp_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (done) begin
				rsp_valid_q <= 1'b1;
			end else if (!freeze) begin
				rsp_valid_q <= 1'b0; // Taken by the decode register.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			req_wid_q <= fi_wid;
			req_pc_q <= fi_pc;
		end
		if (done) begin
			instr_q <= pslverr ? '0 : prdata; // An error returns an illegal word.
		end
	end

	assign icache_busy = state_q != front_end_pkg::apb_idle;
	assign psel = state_q != front_end_pkg::apb_idle;
	assign penable = state_q == front_end_pkg::apb_access;
	assign paddr = req_pc_q;
	assign id_valid = rsp_valid_q;
	assign id_wid = req_wid_q; // Request registers hold until the result is taken.
	assign id_pc = req_pc_q;
	assign id_instr = instr_q;

	assert property (@(posedge clk) disable iff (reset) penable |-> psel)
		else $error("penable without psel in state %s", state_q.name());

	assert property (@(posedge clk) disable iff (reset)
		psel && !(penable && pready) |=> psel && $stable(paddr))
		else $error("paddr changed before pready in state %s", state_q.name());

endmodule

`default_nettype wire

//--- inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
	input  logic dec_valid,
	input  logic [front_end_pkg::nw_bits-1:0] dec_wid,
	input  logic [front_end_pkg::xlen-1:0] dec_pc,
	input  logic [front_end_pkg::xlen-1:0] dec_instr,
	output front_end_pkg::op_class_t op,
	output logic [front_end_pkg::reg_bits-1:0] rd,
	output logic [front_end_pkg::reg_bits-1:0] rs1,
	output logic [front_end_pkg::reg_bits-1:0] rs2,
	output logic [front_end_pkg::xlen-1:0] imm,
	output logic release_valid,
	output logic [front_end_pkg::nw_bits-1:0] release_wid,
	output logic halt_valid
);

	logic [6:0] opcode;
	logic [front_end_pkg::xlen-1:0] imm_i;
	logic [front_end_pkg::xlen-1:0] imm_s;
	logic [front_end_pkg::xlen-1:0] imm_b;
	logic [front_end_pkg::xlen-1:0] imm_u;
	logic [front_end_pkg::xlen-1:0] imm_j;
	logic legal;
	logic holds_warp;

	assign opcode = dec_instr[6:0];

	assign imm_i = {{20{dec_instr[31]}}, dec_instr[31:20]};
	assign imm_s = {{20{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};
	assign imm_b = {{19{dec_instr[31]}}, dec_instr[31], dec_instr[7],
		dec_instr[30:25], dec_instr[11:8], 1'b0};
	assign imm_u = {dec_instr[31:12], 12'b0};
	assign imm_j = {{11{dec_instr[31]}}, dec_instr[31], dec_instr[19:12],
		dec_instr[20], dec_instr[30:21], 1'b0};

	// A misaligned fetch address makes the word illegal whatever it holds.
	always_comb begin
		op = front_end_pkg::op_illegal;
		if (dec_pc[1:0] == 2'b00) begin
			case (opcode)
				front_end_pkg::opc_op: op = front_end_pkg::op_alu;
				front_end_pkg::opc_op_imm: op = front_end_pkg::op_alu_imm;
				front_end_pkg::opc_load: op = front_end_pkg::op_load;
				front_end_pkg::opc_store: op = front_end_pkg::op_store;
				front_end_pkg::opc_branch: op = front_end_pkg::op_branch;
				front_end_pkg::opc_jal: op = front_end_pkg::op_jal;
				front_end_pkg::opc_jalr: op = front_end_pkg::op_jalr;
				front_end_pkg::opc_lui: op = front_end_pkg::op_lui;
				front_end_pkg::opc_auipc: op = front_end_pkg::op_auipc;
				front_end_pkg::opc_system: begin
					if (dec_instr == front_end_pkg::instr_ecall ||
						dec_instr == front_end_pkg::instr_ebreak) begin
						op = front_end_pkg::op_system_halt;
					end
				end
				default: op = front_end_pkg::op_illegal;
			endcase
		end
	end

	always_comb begin
		case (op)
			front_end_pkg::op_alu_imm,
			front_end_pkg::op_load,
			front_end_pkg::op_jalr: imm = imm_i;
			front_end_pkg::op_store: imm = imm_s;
			front_end_pkg::op_branch: imm = imm_b;
			front_end_pkg::op_jal: imm = imm_j;
			front_end_pkg::op_lui,
			front_end_pkg::op_auipc: imm = imm_u;
			default: imm = '0;
		endcase
	end

	assign legal = op != front_end_pkg::op_illegal;
	assign rd = legal ? dec_instr[11:7] : '0;
	assign rs1 = legal ? dec_instr[19:15] : '0;
	assign rs2 = legal ? dec_instr[24:20] : '0;

	// Control flow keeps the warp until the back end sends its target.
	assign holds_warp = (op == front_end_pkg::op_branch) ||
		(op == front_end_pkg::op_jal) ||
		(op == front_end_pkg::op_jalr) ||
		(op == front_end_pkg::op_system_halt);

	assign release_valid = dec_valid && !holds_warp;
	assign release_wid = dec_wid;
	assign halt_valid = dec_valid && (op == front_end_pkg::op_system_halt);

endmodule

`default_nettype wire

//--- front_end.sv
`timescale 1ns/100ps
`default_nettype none

module front_end (
	input  logic clk,
	input  logic reset,
	input  logic schedule_delay,
	input  logic redirect_valid,
	input  logic [front_end_pkg::nw_bits-1:0] redirect_wid,
	input  logic [front_end_pkg::xlen-1:0] redirect_pc,
	output logic psel,
	output logic penable,
	output logic [front_end_pkg::xlen-1:0] paddr,
	input  logic [front_end_pkg::xlen-1:0] prdata,
	input  logic pready,
	input  logic pslverr,
	output logic be_valid,
	output logic [front_end_pkg::nw_bits-1:0] be_wid,
	output logic [front_end_pkg::xlen-1:0] be_pc,
	output front_end_pkg::op_class_t be_op,
	output logic [front_end_pkg::reg_bits-1:0] be_rd,
	output logic [front_end_pkg::reg_bits-1:0] be_rs1,
	output logic [front_end_pkg::reg_bits-1:0] be_rs2,
	output logic [front_end_pkg::xlen-1:0] be_imm,
	output logic fetch_halted
);

	logic fetch_valid;
	logic [front_end_pkg::nw_bits-1:0] fetch_wid;
	logic [front_end_pkg::xlen-1:0] fetch_pc;
	logic fi_valid;
	logic [front_end_pkg::nw_bits-1:0] fi_wid;
	logic [front_end_pkg::xlen-1:0] fi_pc;
	logic icache_busy;
	logic fi_freeze;
	logic id_valid;
	logic [front_end_pkg::nw_bits-1:0] id_wid;
	logic [front_end_pkg::xlen-1:0] id_pc;
	logic [front_end_pkg::xlen-1:0] id_instr;
	logic dec_valid;
	logic [front_end_pkg::nw_bits-1:0] dec_wid;
	logic [front_end_pkg::xlen-1:0] dec_pc;
	logic [front_end_pkg::xlen-1:0] dec_instr;
	front_end_pkg::op_class_t op;
	logic [front_end_pkg::reg_bits-1:0] rd;
	logic [front_end_pkg::reg_bits-1:0] rs1;
	logic [front_end_pkg::reg_bits-1:0] rs2;
	logic [front_end_pkg::xlen-1:0] imm;
	logic release_valid;
	logic [front_end_pkg::nw_bits-1:0] release_wid;
	logic halt_valid;
	logic [front_end_pkg::op_bits-1:0] be_op_raw;

	assign fi_freeze = schedule_delay || icache_busy; // Also holds back new issue.

	warp_fetch fetch (
		.clk(clk), .reset(reset), .stall(fi_freeze),
		.release_valid(release_valid), .release_wid(release_wid),
		.redirect_valid(redirect_valid), .redirect_wid(redirect_wid),
		.redirect_pc(redirect_pc), .halt_valid(halt_valid),
		.fetch_valid(fetch_valid), .fetch_wid(fetch_wid), .fetch_pc(fetch_pc),
		.fetch_halted(fetch_halted)
	);

	stage_reg #(.width(front_end_pkg::fi_width)) fetch_icache_reg (
		.clk(clk), .reset(reset), .freeze(fi_freeze),
		.in_valid(fetch_valid), .in_data({fetch_wid, fetch_pc}),
		.out_valid(fi_valid), .out_data({fi_wid, fi_pc})
	);

	icache_stage icache (
		.clk(clk), .reset(reset), .freeze(schedule_delay),
		.fi_valid(fi_valid), .fi_wid(fi_wid), .fi_pc(fi_pc),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.icache_busy(icache_busy), .id_valid(id_valid), .id_wid(id_wid),
		.id_pc(id_pc), .id_instr(id_instr),
		.psel(psel), .penable(penable), .paddr(paddr)
	);

	stage_reg #(.width(front_end_pkg::id_width)) icache_decode_reg (
		.clk(clk), .reset(reset), .freeze(schedule_delay),
		.in_valid(id_valid), .in_data({id_wid, id_pc, id_instr}),
		.out_valid(dec_valid), .out_data({dec_wid, dec_pc, dec_instr})
	);

	inst_decode decode (
		.dec_valid(dec_valid), .dec_wid(dec_wid), .dec_pc(dec_pc), .dec_instr(dec_instr),
		.op(op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
		.release_valid(release_valid), .release_wid(release_wid), .halt_valid(halt_valid)
	);

	stage_reg #(.width(front_end_pkg::be_width)) decode_backend_reg (
		.clk(clk), .reset(reset), .freeze(schedule_delay),
		.in_valid(dec_valid), .in_data({dec_wid, dec_pc, op, rd, rs1, rs2, imm}),
		.out_valid(be_valid),
		.out_data({be_wid, be_pc, be_op_raw, be_rd, be_rs1, be_rs2, be_imm})
	);

	assign be_op = front_end_pkg::op_class_t'(be_op_raw);

endmodule

`default_nettype wire

//--- tb_front_end.sv
`timescale 1ns/100ps
`default_nettype none

module tb_front_end;

	localparam int prog_len = 12;
	localparam int cycle_limit = 40 * front_end_pkg::num_warps * prog_len;

	logic clk = 1'b0;
	logic reset, schedule_delay, redirect_valid, pready, pslverr;
	logic [1:0] redirect_wid;
	logic [31:0] redirect_pc, prdata;
	logic psel, penable, be_valid, fetch_halted;
	logic [1:0] be_wid;
	logic [31:0] paddr, be_pc, be_imm;
	logic [4:0] be_rd, be_rs1, be_rs2;
	front_end_pkg::op_class_t be_op, exp_op;
	logic [4:0] exp_rd, exp_rs1, exp_rs2;
	logic [31:0] exp_imm, mem [256], xfer_addr, exp_pc [4], target [4];
	logic [85:0] hold_be;
	logic in_xfer, hold_valid, halt_seen, ebreak_seen, err;
	logic [3:0] pending;
	logic err_q [$];
	integer seed = 32'h9789_b8aa;
	int cycles, wait_left, freeze_left, late_setups, idle, delay [4], count [4];

	front_end dut (.*);

	always #5 clk = ~clk;

	task automatic check(input logic [95:0] actual, input logic [95:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic drive_read(input logic [31:0] addr);
		logic [31:0] word;
		word = mem[addr[9:2]];
		prdata <= word;
		pready <= 1'b1;
		pslverr <= (word != 32'h0010_0073) && (($random(seed) & 15) == 0); // Never on ebreak.
	endtask

	// Expected decode, taken from the RV32I encoding tables.
	function automatic void ref_decode(input logic [31:0] w, output front_end_pkg::op_class_t op,
		output logic [4:0] rd, output logic [4:0] rs1, output logic [4:0] rs2,
		output logic [31:0] imm);
		logic [31:0] sx;
		sx = {32{w[31]}};
		op = front_end_pkg::op_illegal;
		imm = '0;
		case (w[6:0])
			7'h33: op = front_end_pkg::op_alu;
			7'h13: begin
				op = front_end_pkg::op_alu_imm;
				imm = {sx[19:0], w[31:20]};
			end
			7'h03: begin
				op = front_end_pkg::op_load;
				imm = {sx[19:0], w[31:20]};
			end
			7'h23: begin
				op = front_end_pkg::op_store;
				imm = {sx[19:0], w[31:25], w[11:7]};
			end
			7'h63: begin
				op = front_end_pkg::op_branch;
				imm = {sx[19:0], w[7], w[30:25], w[11:8], 1'b0};
			end
			7'h6f: begin
				op = front_end_pkg::op_jal;
				imm = {sx[11:0], w[19:12], w[20], w[30:21], 1'b0};
			end
			7'h67: begin
				op = front_end_pkg::op_jalr;
				imm = {sx[19:0], w[31:20]};
			end
			7'h37: begin
				op = front_end_pkg::op_lui;
				imm = {w[31:12], 12'h000};
			end
			7'h17: begin
				op = front_end_pkg::op_auipc;
				imm = {w[31:12], 12'h000};
			end
			7'h73: if (w == 32'h73 || w == 32'h0010_0073) op = front_end_pkg::op_system_halt;
			default: op = front_end_pkg::op_illegal;
		endcase
		rd = (op == front_end_pkg::op_illegal) ? 5'd0 : w[11:7];
		rs1 = (op == front_end_pkg::op_illegal) ? 5'd0 : w[19:15];
		rs2 = (op == front_end_pkg::op_illegal) ? 5'd0 : w[24:20];
	endfunction

	// Branches skip one slot, jal loops back except on warp 3 where it lands on ebreak.
	function automatic logic [31:0] ctrl_target(input int w, input logic [31:0] pc);
		logic [31:0] base;
		base = front_end_pkg::start_pc + w * front_end_pkg::warp_pc_stride;
		if (pc - base == 32'd20) return pc + 32'd8;
		return (w == 3) ? base + 32'd44 : base;
	endfunction

	initial begin
		logic [6:0] kinds [6];
		logic [31:0] addr;
		kinds = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h37, 7'h17};
		{reset, schedule_delay, redirect_valid, redirect_wid, redirect_pc} = '1;
		{schedule_delay, redirect_valid, redirect_wid, redirect_pc} = '0;
		{prdata, pready, pslverr} = '0;
		{in_xfer, hold_valid, halt_seen, ebreak_seen, pending} = '0;
		{cycles, wait_left, freeze_left, late_setups, idle} = '0;
		for (int i = 0; i < 256; i++) begin
			addr = 32'h1000 + i * 4;
			mem[i] = {addr[24:0] ^ addr[31:7], 7'h33};
		end
		for (int w = 0; w < 4; w++) begin
			exp_pc[w] = front_end_pkg::start_pc + w * front_end_pkg::warp_pc_stride;
			{delay[w], count[w]} = '0;
			for (int s = 0; s < prog_len; s++) begin
				mem[w * 64 + s] = $random(seed);
				mem[w * 64 + s][6:0] = (s == 5) ? 7'h63 : (s == 10) ? 7'h6f : kinds[(s + w) % 6];
			end
		end
		mem[3 * 64 + 11] = 32'h0010_0073;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	end

	always @(posedge clk) begin
		if (!reset) begin
			cycles++;
			if (psel && !penable) begin
				check(in_xfer, 0, "setup phase started inside a transfer");
				late_setups += halt_seen;
				in_xfer = 1'b1;
				xfer_addr = paddr;
				wait_left = $random(seed) & 3;
				if (wait_left == 0) drive_read(paddr);
				else pready <= 1'b0;
			end else if (psel && penable) begin
				check(in_xfer, 1, "access phase without setup");
				check(paddr, xfer_addr, "paddr changed before pready");
				if (pready) begin
					err_q.push_back(pslverr);
					in_xfer = 1'b0;
					{pready, pslverr} <= 2'b00;
				end else if (--wait_left == 0) begin
					drive_read(paddr);
				end
			end else begin
				check(in_xfer, 0, "psel dropped before pready");
			end
			halt_seen |= fetch_halted;
			check(late_setups <= 1, 1, "new fetch started after the halt");
			if (ebreak_seen) check(fetch_halted, 1, "fetch_halted low after ebreak");
			if (hold_valid) begin
				check({be_valid, be_wid, be_op, be_rd, be_rs1, be_rs2, be_pc, be_imm}, hold_be,
					"be changed in freeze");
			end
			hold_valid = schedule_delay && be_valid;
			hold_be = {be_valid, be_wid, be_op, be_rd, be_rs1, be_rs2, be_pc, be_imm};
			for (int w = 0; w < 4; w++) begin
				if (redirect_valid && redirect_wid == w) pending[w] = 1'b0;
			end
			redirect_valid <= 1'b0;
			for (int w = 3; w >= 0; w--) begin
				if (pending[w] && delay[w] > 0) delay[w]--;
				if (pending[w] && delay[w] == 0) begin
					redirect_valid <= 1'b1;
					redirect_wid <= w[1:0];
					redirect_pc <= target[w];
				end
			end
			if (be_valid && !schedule_delay) begin
				check(err_q.size() > 0, 1, "instruction on be without an APB read");
				err = err_q.pop_front();
				check(pending[be_wid], 0, "warp issued before its redirect");
				check(be_wid, (be_pc - front_end_pkg::start_pc) / front_end_pkg::warp_pc_stride,
					"be_wid does not own be_pc");
				check(be_pc, exp_pc[be_wid], "be_pc off the warp's program");
				ref_decode(err ? 32'h0 : mem[be_pc[9:2]], exp_op, exp_rd, exp_rs1, exp_rs2, exp_imm);
				check(be_op, exp_op, "be_op");
				check({be_rd, be_rs1, be_rs2}, {exp_rd, exp_rs1, exp_rs2}, "register fields");
				check(be_imm, exp_imm, "be_imm");
				count[be_wid]++;
				exp_pc[be_wid] = be_pc + 32'd4;
				if (exp_op == front_end_pkg::op_branch || exp_op == front_end_pkg::op_jal) begin
					target[be_wid] = ctrl_target(be_wid, be_pc);
					exp_pc[be_wid] = target[be_wid];
					pending[be_wid] = 1'b1;
					delay[be_wid] = 1 + ($random(seed) & 3);
				end
				if (exp_op == front_end_pkg::op_system_halt) ebreak_seen = 1'b1;
			end
			if (freeze_left == 0 && ($random(seed) & 15) == 0) freeze_left = 1 + ($random(seed) & 3);
			schedule_delay <= freeze_left != 0;
			if (freeze_left != 0) freeze_left--;
			idle = (ebreak_seen && !psel && !be_valid) ? idle + 1 : 0;
			if (idle == 30) begin
				for (int w = 0; w < 4; w++) check(count[w] > 0, 1, "a warp never reached be");
				$display("Regression passed");
				$finish;
			end
		end
	end

	always @(negedge clk) begin
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("Regression failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- list.f
front_end_pkg.sv
warp_fetch.sv
stage_reg.sv
icache_stage.sv
inst_decode.sv
front_end.sv
tb_front_end.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_front_end
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
